//--- logic/uart_rx_pkg.sv
package uart_rx_pkg;

  // --------------------------------------------------------------------------
  // Bit timing
  // --------------------------------------------------------------------------
  localparam int unsigned OVERSAMPLE     = 16; // Ticks per bit
  localparam int unsigned BIT_CENTER     = 8;
  localparam int unsigned MAJ_INIT       = 4;  // Vote counter cleared here
  localparam int unsigned MAJ_DECIDE     = 7;  // Third sample and decision
  localparam int unsigned START_OFFSET   = 2;  // Edge seen on a tick
  localparam int unsigned NR_SYNC_STAGES = 2;
  localparam int unsigned DATA_W         = 8;
  localparam int unsigned TIMING_W       = 5;

  // --------------------------------------------------------------------------
  // Line configuration
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {WLEN_5, WLEN_6, WLEN_7, WLEN_8} word_len_e;
  typedef enum logic [1:0] {PAR_ODD, PAR_EVEN, PAR_ONE, PAR_ZERO} par_mode_e;
  typedef enum logic [1:0] {TRIG_1, TRIG_4, TRIG_8, TRIG_14} trig_lvl_e;

  typedef struct packed {
    word_len_e word_len;
    logic      par_en;   // Parity bit present
    par_mode_e par_mode;
    trig_lvl_e trig_lvl;
  } rx_cfg_t;

  // Received character with its status
  typedef struct packed {
    logic [DATA_W-1:0] data;      // Right-aligned
    logic              par_err;
    logic              frame_err;
    logic              brk;
  } rx_char_t;

  typedef enum logic [2:0] {
    RX_IDLE, RX_START, RX_DATA, RX_PAR, RX_STOP, RX_RESYNC
  } rx_state_e;

  // One strobe per bit center, from FSM to shift datapath
  typedef struct packed {
    logic clear;
    logic shift;
    logic check_par;
    logic check_stop;
  } deframe_ctl_t;

endpackage

//--- logic/rx_sampler.sv
module rx_sampler (
  input  logic clk_i,
  input  logic rst_i,
  input  logic os_tick_i,      // One clock per oversample period
  input  logic rxd_i,          // Asynchronous serial line
  input  logic hunt_i,         // No bit lock yet
  input  logic timing_load_i,
  output logic rxd_filt_o,
  output logic start_edge_o,
  output logic bit_center_o
);
  import uart_rx_pkg::*;

  logic [NR_SYNC_STAGES-1:0] sync_q;
  logic                      sync_rxd;
  logic [TIMING_W-1:0]       timing_q;
  logic                      center_lvl;
  logic                      center_q;
  logic [1:0]                high_cnt_q;   // Highs seen so far in this vote
  logic                      filt_q;

  // --------------------------------------------------------------------------
  // Synchronizer and oversample counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '1; // Idle line is high
    end else begin
      sync_q <= {sync_q[NR_SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign sync_rxd = sync_q[NR_SYNC_STAGES-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      timing_q <= '0;
    end else if (timing_load_i) begin
      timing_q <= TIMING_W'(START_OFFSET); // Edge coincided with a tick
    end else if (hunt_i) begin
      timing_q <= '0;
    end else if (os_tick_i) begin
      if (timing_q == TIMING_W'(OVERSAMPLE - 1)) begin
        timing_q <= '0;
      end else begin
        timing_q <= timing_q + 1'b1;
      end
    end
  end

  // Count sits at center for a whole tick period, pulse on its first clock
  assign center_lvl   = (timing_q == TIMING_W'(BIT_CENTER));
  assign bit_center_o = center_lvl & ~center_q;

  // --------------------------------------------------------------------------
  // Three-sample majority vote
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      center_q   <= 1'b0;
      high_cnt_q <= '0;
      filt_q     <= 1'b1;
    end else begin
      center_q <= center_lvl;
      if (hunt_i) begin
        filt_q <= sync_rxd; // Follow the line until locked
      end else if (os_tick_i) begin
        if (timing_q == TIMING_W'(MAJ_INIT)) begin
          high_cnt_q <= '0;
        end else if ((timing_q > TIMING_W'(MAJ_INIT)) &&
                     (timing_q < TIMING_W'(MAJ_DECIDE))) begin
          high_cnt_q <= high_cnt_q + 2'(sync_rxd);
        end else if (timing_q == TIMING_W'(MAJ_DECIDE)) begin
          filt_q <= ((high_cnt_q + 2'(sync_rxd)) >= 2'd2); // Two of three
        end
      end
    end
  end

  assign rxd_filt_o   = filt_q;
  assign start_edge_o = hunt_i & filt_q & ~sync_rxd; // Falling edge
endmodule

//--- logic/rx_ctrl.sv
module rx_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      os_tick_i,
  input  uart_rx_pkg::rx_cfg_t      cfg_i,
  input  logic                      start_edge_i,
  input  logic                      bit_center_i,
  input  logic                      rxd_filt_i,
  input  logic                      frame_err_i,   // Stop bit read low
  output logic                      hunt_o,
  output logic                      timing_load_o,
  output uart_rx_pkg::deframe_ctl_t deframe_ctl_o
);
  import uart_rx_pkg::*;

  rx_state_e  state_q;
  rx_state_e  state_d;
  logic [2:0] bit_cnt_q;   // Index of next data bit
  logic [2:0] bit_cnt_d;
  logic [2:0] last_bit;

  // Word length codes start at 5 bits, index 4
  assign last_bit = 3'(cfg_i.word_len) + 3'd4;

  // --------------------------------------------------------------------------
  // Receive FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    bit_cnt_d     = bit_cnt_q;
    deframe_ctl_o = '0;
    case (state_q)
      RX_IDLE: begin
        if (start_edge_i) begin
          state_d = RX_START;
        end
      end
      RX_START: begin
        if (bit_center_i) begin
          if (!rxd_filt_i) begin
            deframe_ctl_o.clear = 1'b1;
            bit_cnt_d           = '0;
            state_d             = RX_DATA;
          end else begin
            state_d = RX_IDLE; // Glitch, not a start bit
          end
        end
      end
      RX_DATA: begin
        if (bit_center_i) begin
          deframe_ctl_o.shift = 1'b1;
          bit_cnt_d           = bit_cnt_q + 1'b1;
          if (bit_cnt_q == last_bit) begin
            state_d = cfg_i.par_en ? RX_PAR : RX_STOP;
          end
        end
      end
      RX_PAR: begin
        if (bit_center_i) begin
          deframe_ctl_o.check_par = 1'b1;
          state_d                 = RX_STOP;
        end
      end
      RX_STOP: begin
        if (bit_center_i) begin
          deframe_ctl_o.check_stop = 1'b1;
          state_d = frame_err_i ? RX_RESYNC : RX_IDLE;
        end
      end
      RX_RESYNC: begin
        if (start_edge_i) begin
          state_d = RX_START;    // Next frame follows directly
        end else if (rxd_filt_i) begin
          state_d = RX_IDLE;     // Line back to idle level
        end
      end
      default: state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      bit_cnt_q <= bit_cnt_d;
    end
  end

  assign hunt_o        = (state_q == RX_IDLE) || (state_q == RX_RESYNC);
  assign timing_load_o = hunt_o & start_edge_i & os_tick_i;
endmodule

//--- logic/rx_deframer.sv
module rx_deframer (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  uart_rx_pkg::rx_cfg_t      cfg_i,
  input  uart_rx_pkg::deframe_ctl_t ctl_i,
  input  logic                      rxd_filt_i,
  output uart_rx_pkg::rx_char_t     char_o,
  output logic                      char_done_o,
  output logic                      frame_err_o
);
  import uart_rx_pkg::*;

  logic [DATA_W-1:0] shreg_q;       // LSB first, fills from the top
  logic [DATA_W-1:0] data_aligned;
  logic              data_par;
  logic              par_err;
  logic              par_err_q;
  logic              par_zero_q;    // Parity bit was low, for break
  logic              brk;
  rx_char_t          char_q;
  logic              done_q;

  // Short words sit in the upper bits, shift them down
  assign data_aligned = shreg_q >> (2'd3 - cfg_i.word_len);
  assign data_par     = ^data_aligned;

  always_comb begin
    case (cfg_i.par_mode)
      PAR_ODD:  par_err = (rxd_filt_i == data_par);
      PAR_EVEN: par_err = (rxd_filt_i != data_par);
      PAR_ONE:  par_err = ~rxd_filt_i;
      default:  par_err = rxd_filt_i; // Forced 0
    endcase
  end

  // --------------------------------------------------------------------------
  // Stop bit and break
  // --------------------------------------------------------------------------
  assign frame_err_o = ctl_i.check_stop & ~rxd_filt_i;
  assign brk = (data_aligned == '0) & (~cfg_i.par_en | par_zero_q) & ~rxd_filt_i;

  always_ff @(posedge clk_i) begin
    if (ctl_i.clear) begin
      shreg_q <= '0;
    end else if (ctl_i.shift) begin
      shreg_q <= {rxd_filt_i, shreg_q[DATA_W-1:1]};
    end
    if (ctl_i.check_stop) begin
      char_q.data      <= data_aligned;
      char_q.par_err   <= par_err_q;
      char_q.frame_err <= frame_err_o;
      char_q.brk       <= brk;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      par_err_q  <= 1'b0;
      par_zero_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= ctl_i.check_stop;
      if (ctl_i.clear) begin
        par_err_q  <= 1'b0; // Stays clear without a parity bit
        par_zero_q <= 1'b0;
      end else if (ctl_i.check_par) begin
        par_err_q  <= par_err;
        par_zero_q <= ~rxd_filt_i;
      end
    end
  end

  assign char_o      = char_q;
  assign char_done_o = done_q;
endmodule

//--- logic/rx_fifo.sv
module rx_fifo #(
  parameter int unsigned DEPTH = 16,
  parameter type         payload_t = logic
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       push_i,
  input  payload_t                   data_i,
  input  logic                       pop_i,
  output payload_t                   data_o,   // Head, valid while not empty
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] usage_o
);
  localparam int unsigned ADDR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W  = $clog2(DEPTH + 1);

  payload_t          mem_q [DEPTH];
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q; // Both or neither
      endcase
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign usage_o = cnt_q;
endmodule

//--- logic/rx_credit_out.sv
module rx_credit_out #(
  parameter int unsigned CREDITS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  uart_rx_pkg::rx_char_t head_i,
  input  logic                  empty_i,
  input  logic                  credit_i,      // One credit back per pulse
  output logic                  pop_o,
  output uart_rx_pkg::rx_char_t char_o,
  output logic                  char_valid_o
);
  import uart_rx_pkg::*;

  localparam int unsigned CRED_W = $clog2(CREDITS + 1);

  logic [CRED_W-1:0] credit_q;
  rx_char_t          char_q;
  logic              valid_q;

  // Send whenever a credit is held and a character waits
  assign pop_o = (credit_q != '0) & ~empty_i;

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      char_q <= head_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= CRED_W'(CREDITS);
      valid_q  <= 1'b0;
    end else begin
      valid_q <= pop_o;
      case ({pop_o, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q; // Spend and return cancel
      endcase
    end
  end

  assign char_o       = char_q;
  assign char_valid_o = valid_q;
endmodule

//--- logic/uart_rx.sv
module uart_rx #(
  parameter int unsigned FIFO_DEPTH = 16,
  parameter int unsigned RX_CREDITS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  os_tick_i,
  input  logic                  rxd_i,
  input  uart_rx_pkg::rx_cfg_t  cfg_i,         // Static during a frame
  output uart_rx_pkg::rx_char_t char_o,
  output logic                  char_valid_o,
  input  logic                  credit_i,
  output logic                  trigger_o,
  output logic                  overrun_o
);
  import uart_rx_pkg::*;

  localparam int unsigned USAGE_W = $clog2(FIFO_DEPTH + 1);

  logic               rxd_filt;
  logic               start_edge;
  logic               bit_center;
  logic               hunt;
  logic               timing_load;
  deframe_ctl_t       deframe_ctl;
  logic               frame_err;
  rx_char_t           rx_char;
  logic               char_done;
  logic               fifo_push;
  logic               fifo_pop;
  logic               fifo_empty;
  logic               fifo_full;
  logic [USAGE_W-1:0] fifo_usage;
  rx_char_t           fifo_head;
  logic [USAGE_W-1:0] trig_chars;

  // --------------------------------------------------------------------------
  // Receive front end
  // --------------------------------------------------------------------------
  rx_sampler i_sampler (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .os_tick_i     (os_tick_i),
    .rxd_i         (rxd_i),
    .hunt_i        (hunt),
    .timing_load_i (timing_load),
    .rxd_filt_o    (rxd_filt),
    .start_edge_o  (start_edge),
    .bit_center_o  (bit_center)
  );

  rx_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .os_tick_i     (os_tick_i),
    .cfg_i         (cfg_i),
    .start_edge_i  (start_edge),
    .bit_center_i  (bit_center),
    .rxd_filt_i    (rxd_filt),
    .frame_err_i   (frame_err),
    .hunt_o        (hunt),
    .timing_load_o (timing_load),
    .deframe_ctl_o (deframe_ctl)
  );

  rx_deframer i_deframer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_i       (cfg_i),
    .ctl_i       (deframe_ctl),
    .rxd_filt_i  (rxd_filt),
    .char_o      (rx_char),
    .char_done_o (char_done),
    .frame_err_o (frame_err)
  );

  // --------------------------------------------------------------------------
  // Character buffer and credit link
  // --------------------------------------------------------------------------
  assign fifo_push = char_done & ~fifo_full;
  assign overrun_o = char_done & fifo_full;   // Character is lost

  rx_fifo #(
    .DEPTH     (FIFO_DEPTH),
    .payload_t (rx_char_t)
  ) i_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (fifo_push),
    .data_i  (rx_char),
    .pop_i   (fifo_pop),
    .data_o  (fifo_head),
    .empty_o (fifo_empty),
    .full_o  (fifo_full),
    .usage_o (fifo_usage)
  );

  rx_credit_out #(
    .CREDITS (RX_CREDITS)
  ) i_credit_out (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_i       (fifo_head),
    .empty_i      (fifo_empty),
    .credit_i     (credit_i),
    .pop_o        (fifo_pop),
    .char_o       (char_o),
    .char_valid_o (char_valid_o)
  );

  // Trigger level in characters
  always_comb begin
    case (cfg_i.trig_lvl)
      TRIG_1:  trig_chars = USAGE_W'(1);
      TRIG_4:  trig_chars = USAGE_W'(4);
      TRIG_8:  trig_chars = USAGE_W'(8);
      default: trig_chars = USAGE_W'(14);
    endcase
  end

  assign trigger_o = (fifo_usage >= trig_chars);
endmodule

//--- verif/uart_rx_asserts.sv
module uart_rx_asserts #(
  parameter int FIFO_DEPTH = 16,
  parameter int RX_CREDITS = 2
) (
  input logic clk_i,
  input logic rst_i,
  input logic push_i,
  input logic pop_i,
  input logic credit_i,
  input logic char_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fill_q;          // Characters stored, from push and pop alone
  int cred_q;          // Credits held by the sender
  int sent_q;          // Characters on the link not yet returned
  int error_cnt = 0;   // Assertion failures so far

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fill_q <= 0;
      cred_q <= RX_CREDITS;
      sent_q <= 0;
    end else begin
      fill_q <= fill_q + int'(push_i) - int'(pop_i);
      cred_q <= cred_q + int'(credit_i) - int'(pop_i);
      sent_q <= sent_q + int'(char_valid_i) - int'(credit_i);
    end
  end

  // --------------------------------------------------------------------------
  // FIFO and credit link
  // --------------------------------------------------------------------------
  push_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> (fill_q < FIFO_DEPTH))
    else begin
      $error("FIFO written while full");
      error_cnt++;
    end

  pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> (fill_q > 0))
    else begin
      $error("FIFO read while empty");
      error_cnt++;
    end

  credits_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
    (cred_q >= 0) && (cred_q <= RX_CREDITS))
    else begin
      $error("Credit count out of range");
      error_cnt++;
    end

  // Back to back valids only while credits cover them all
  valid_covered: assert property (@(posedge clk_i) disable iff (rst_i) sent_q <= RX_CREDITS)
    else begin
      $error("Characters sent beyond the credits returned");
      error_cnt++;
    end
endmodule

bind uart_rx uart_rx_asserts #(
  .FIFO_DEPTH (FIFO_DEPTH),
  .RX_CREDITS (RX_CREDITS)
) u_asserts (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .push_i       (fifo_push),
  .pop_i        (fifo_pop),
  .credit_i     (credit_i),
  .char_valid_i (char_valid_o)
);

//--- verif/tb_uart_rx.sv
module tb_uart_rx;
  timeunit 1ns;
  timeprecision 1ps;
  import uart_rx_pkg::*;

  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned RX_CREDITS = 2;
  localparam int BIT_CLKS   = 4 * OVERSAMPLE;  // Tick every 4 clocks
  localparam int GLITCH_AT  = 24;              // Hits one of the three votes
  localparam int NR_FRAMES  = 8 + 12 + 3 + 2 + (RX_CREDITS + FIFO_DEPTH + 1);
  localparam int MAX_CYCLES = NR_FRAMES * 12 * BIT_CLKS * 2;

  logic     clk     = 1'b0;
  logic     rst     = 1'b1;
  logic     os_tick = 1'b0;
  logic     rxd     = 1'b1;
  logic     credit  = 1'b0;
  rx_cfg_t  cfg     = '{word_len: WLEN_8, par_en: 1'b0, par_mode: PAR_EVEN, trig_lvl: TRIG_14};
  rx_char_t char_out;
  logic     char_valid;
  logic     trigger;
  logic     overrun;

  int       tick_div  = 0;
  int       cycle_cnt = 0;
  rx_char_t got_q [$];       // Characters seen on the link
  int       recv_cnt  = 0;
  int       ret_cnt   = 0;   // Credits handed back
  bit       credit_en = 1'b1;
  int       ovr_cnt   = 0;
  int       err_cnt   = 0;
  int       test_cnt  = 0;
  int       fail_cnt  = 0;
  int       test_err_base;
  string    cur_test;

  uart_rx #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .RX_CREDITS (RX_CREDITS)
  ) dut_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .os_tick_i    (os_tick),
    .rxd_i        (rxd),
    .cfg_i        (cfg),
    .char_o       (char_out),
    .char_valid_o (char_valid),
    .credit_i     (credit),
    .trigger_o    (trigger),
    .overrun_o    (overrun)
  );

  // --------------------------------------------------------------------------
  // Clock, oversample tick, link consumer
  // --------------------------------------------------------------------------
  always #20 clk = ~clk;

  always @(negedge clk) begin
    tick_div <= (tick_div == 3) ? 0 : tick_div + 1;
    os_tick  <= (tick_div == 3);
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (!rst && char_valid) begin
      got_q.push_back(char_out);
      recv_cnt <= recv_cnt + 1;
    end
    if (!rst && overrun) begin
      ovr_cnt <= ovr_cnt + 1;
    end
  end

  // One credit back per character while enabled
  always @(negedge clk) begin
    if (credit_en && (ret_cnt < recv_cnt)) begin
      credit  <= 1'b1;
      ret_cnt <= ret_cnt + 1;
    end else begin
      credit <= 1'b0;
    end
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("Timeout after %0d cycles, a test did not finish", cycle_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    if (err_cnt != test_err_base) begin
      fail_cnt++;
    end
    $display("%-14s done, %0d error(s)", cur_test, err_cnt - test_err_base);
  endtask

  function automatic logic [7:0] word_mask(input int len);
    return 8'((1 << len) - 1);
  endfunction

  // Parity bit the sender puts on the line
  function automatic logic parity_bit(input logic [7:0] data, input par_mode_e mode);
    case (mode)
      PAR_ODD:  return ~(^data);   // Total ones odd
      PAR_EVEN: return ^data;
      PAR_ONE:  return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic rx_char_t make_char(input logic [7:0] data, input logic p_err,
                                         input logic f_err, input logic brk);
    rx_char_t c;
    c.data      = data;
    c.par_err   = p_err;
    c.frame_err = f_err;
    c.brk       = brk;
    return c;
  endfunction

  task automatic idle_line(input int clks);
    rxd = 1'b1;
    repeat (clks) @(negedge clk);
  endtask

  // One tick wide glitch inside the vote window
  task automatic drive_bit(input logic b, input bit glitch);
    for (int i = 0; i < BIT_CLKS; i++) begin
      rxd = (glitch && (i >= GLITCH_AT) && (i < GLITCH_AT + 4)) ? ~b : b;
      @(negedge clk);
    end
  endtask

  task automatic send_frame(input logic [7:0] data, input int len, input bit par_en,
                            input par_mode_e mode, input bit bad_par, input logic stop_bit,
                            input int glitch_bit);
    logic [7:0] field;
    logic       par;
    field        = data & word_mask(len);
    par          = parity_bit(field, mode) ^ bad_par;
    cfg.word_len = word_len_e'(2'(len - 5));
    cfg.par_en   = par_en;
    cfg.par_mode = mode;
    drive_bit(1'b0, 1'b0);                     // Start bit
    for (int i = 0; i < len; i++) begin
      drive_bit(field[i], (i == glitch_bit));  // LSB first
    end
    if (par_en) begin
      drive_bit(par, 1'b0);
    end
    drive_bit(stop_bit, 1'b0);
    idle_line(8);
  endtask

  task automatic wait_chars(input int n, input int limit);
    int waited;
    waited = 0;
    while ((got_q.size() < n) && (waited < limit)) begin
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic expect_char(input rx_char_t exp);
    wait_chars(1, 4 * BIT_CLKS);
    if (got_q.size() == 0) begin
      $display("[ERROR] %s: no character arrived on the output link", cur_test);
      err_cnt++;
    end else begin
      check_value("character", 32'(exp), 32'(got_q.pop_front()));
    end
  endtask

  task automatic set_credit_return(input bit en);
    @(posedge clk);
    credit_en = en;
    @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_8n1_bytes();
    logic [7:0] b;
    start_test("8n1_bytes");
    for (int i = 0; i < 8; i++) begin
      b = 8'($urandom());
      send_frame(b, 8, 1'b0, PAR_EVEN, 1'b0, 1'b1, (i == 3) ? 2 : -1);
      expect_char(make_char(b, 1'b0, 1'b0, 1'b0));
    end
    end_test();
  endtask

  task automatic test_short_parity();
    logic [7:0] b;
    start_test("short_parity");
    for (int len = 5; len <= 7; len++) begin
      for (int m = 0; m < 4; m++) begin
        b = 8'($urandom());
        send_frame(b, len, 1'b1, par_mode_e'(2'(m)), 1'b0, 1'b1, -1);
        expect_char(make_char(b & word_mask(len), 1'b0, 1'b0, 1'b0));
      end
    end
    end_test();
  endtask

  task automatic test_error_flags();
    logic [7:0] b;
    start_test("error_flags");
    send_frame(8'ha5, 8, 1'b1, PAR_EVEN, 1'b1, 1'b1, -1);  // Parity inverted
    expect_char(make_char(8'ha5, 1'b1, 1'b0, 1'b0));
    send_frame(8'h3c, 8, 1'b0, PAR_EVEN, 1'b0, 1'b0, -1);  // Stop bit low
    expect_char(make_char(8'h3c, 1'b0, 1'b1, 1'b0));
    b = 8'($urandom());
    send_frame(b, 8, 1'b0, PAR_EVEN, 1'b0, 1'b1, -1);
    expect_char(make_char(b, 1'b0, 1'b0, 1'b0));
    end_test();
  endtask

  task automatic test_break();
    logic [7:0] b;
    start_test("break");
    send_frame(8'h00, 8, 1'b0, PAR_EVEN, 1'b0, 1'b0, -1);
    expect_char(make_char(8'h00, 1'b0, 1'b1, 1'b1));
    idle_line(2 * BIT_CLKS);   // Line back high for the resync
    b = 8'($urandom());
    send_frame(b, 8, 1'b0, PAR_EVEN, 1'b0, 1'b1, -1);
    expect_char(make_char(b, 1'b0, 1'b0, 1'b0));
    end_test();
  endtask

  task automatic test_backpressure();
    logic [7:0] b;
    logic [7:0] sent_q [$];
    int         ovr_base;
    start_test("backpressure");
    set_credit_return(1'b0);
    ovr_base = ovr_cnt;
    for (int i = 0; i < RX_CREDITS + FIFO_DEPTH + 1; i++) begin
      b = 8'($urandom());
      sent_q.push_back(b);
      send_frame(b, 8, 1'b0, PAR_EVEN, 1'b0, 1'b1, -1);
      // FIFO holds i + 1 - RX_CREDITS characters here
      if (i == RX_CREDITS + 12) begin
        check_value("trigger at 13 stored", 0, 32'(trigger));
      end
      if (i == RX_CREDITS + 13) begin
        check_value("trigger at 14 stored", 1, 32'(trigger));
      end
    end
    check_value("characters sent without credit", RX_CREDITS, got_q.size());
    check_value("overrun pulses", 1, ovr_cnt - ovr_base);
    for (int i = 0; i < RX_CREDITS; i++) begin
      expect_char(make_char(sent_q[i], 1'b0, 1'b0, 1'b0));
    end
    set_credit_return(1'b1);
    wait_chars(FIFO_DEPTH, 8 * BIT_CLKS);
    idle_line(2 * BIT_CLKS);   // Room for a stray extra character
    check_value("characters drained", FIFO_DEPTH, got_q.size());
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      expect_char(make_char(sent_q[RX_CREDITS + i], 1'b0, 1'b0, 1'b0));
    end
    check_value("trigger after drain", 0, 32'(trigger));
    end_test();
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(32'hdf4b));
    repeat (4) @(negedge clk);
    rst = 1'b0;
    idle_line(2 * BIT_CLKS);
    test_8n1_bytes();
    test_short_parity();
    test_error_flags();
    test_break();
    test_backpressure();
    $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             test_cnt, fail_cnt, err_cnt, dut_i.u_asserts.error_cnt);
    if ((err_cnt == 0) && (dut_i.u_asserts.error_cnt == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end
endmodule

//--- uart_rx.f
logic/uart_rx_pkg.sv
logic/rx_sampler.sv
logic/rx_ctrl.sv
logic/rx_deframer.sv
logic/rx_fifo.sv
logic/rx_credit_out.sv
logic/uart_rx.sv
verif/uart_rx_asserts.sv
verif/tb_uart_rx.sv

//--- run.sh
#!/bin/sh
# Build and run the UART receive testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module tb_uart_rx -f uart_rx.f
./obj_dir/Vtb_uart_rx | tee "$LOG"

if grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "run.sh: simulation ok"
  exit 0
fi
echo "run.sh: simulation reported a problem, see $LOG"
exit 1
